// ==== source/udp_echo_pkg.sv ====
/*
 * UDP echo package
 * Payload stream widths, header field types and the fixed values
 * that the downstream UDP stack places into every reply
 */
package udp_echo_pkg;

    // Payload stream
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // Header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Port that is answered unless the top level overrides it
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // Reply source address, filled in by the downstream stack
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Fixed IP fields of every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;
    localparam logic [5:0] REPLY_DSCP = 6'd0;
    localparam logic [1:0] REPLY_ECN = 2'd0;

    // Zero means no UDP checksum is sent
    localparam logic [15:0] REPLY_CHECKSUM = 16'd0;

endpackage

// ==== source/udp_port_filter.sv ====
/*
 * UDP port filter
 * Forwards headers addressed to the echo port and sinks all others,
 * then admits or discards the payload frame by frame
 */
`timescale 1ns/100ps

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  s_hdr_src_ip,
    input  udp_echo_pkg::udp_port_t s_hdr_src_port,
    input  udp_echo_pkg::udp_port_t s_hdr_dest_port,
    input  udp_echo_pkg::udp_len_t  s_hdr_length,

    input  udp_echo_pkg::data_t     s_payload_data,
    input  udp_echo_pkg::keep_t     s_payload_keep,
    input  logic                    s_payload_valid,
    output logic                    s_payload_ready,
    input  logic                    s_payload_last,
    input  logic                    s_payload_user,

    output logic                    fwd_hdr_valid,
    input  logic                    fwd_hdr_ready,
    output udp_echo_pkg::ip_addr_t  fwd_src_ip,
    output udp_echo_pkg::udp_port_t fwd_src_port,
    output udp_echo_pkg::udp_port_t fwd_dest_port,
    output udp_echo_pkg::udp_len_t  fwd_length,

    output udp_echo_pkg::data_t     fifo_in_data,
    output udp_echo_pkg::keep_t     fifo_in_keep,
    output logic                    fifo_in_valid,
    input  logic                    fifo_in_ready,
    output logic                    fifo_in_last,
    output logic                    fifo_in_user
);

    logic port_match;
    logic echo_active;
    logic drop_active;
    logic payload_xfer;

    assign port_match = (s_hdr_dest_port == ECHO_PORT);

    // Matching headers wait for the reply register, others are sunk at once
    assign fwd_hdr_valid = s_hdr_valid && port_match;
    assign s_hdr_ready = s_hdr_valid && (port_match ? fwd_hdr_ready : 1'b1);

    assign fwd_src_ip = s_hdr_src_ip;
    assign fwd_src_port = s_hdr_src_port;
    assign fwd_dest_port = s_hdr_dest_port;
    assign fwd_length = s_hdr_length;

    assign fifo_in_data = s_payload_data;
    assign fifo_in_keep = s_payload_keep;
    assign fifo_in_valid = s_payload_valid && echo_active;
    assign fifo_in_last = s_payload_last;
    assign fifo_in_user = s_payload_user;

    // Stalled until a flag is set
    assign s_payload_ready = (echo_active && fifo_in_ready) || drop_active;
    assign payload_xfer = s_payload_valid && s_payload_ready;

    // Decision is taken on the first beat and renewed at each frame end
    always_ff @(posedge clk) begin
        if (rst) begin
            echo_active <= 1'b0;
            drop_active <= 1'b0;
        end else if (s_payload_valid) begin
            if ((!echo_active && !drop_active) || (payload_xfer && s_payload_last)) begin
                echo_active <= port_match;
                drop_active <= !port_match;
            end
        end else begin
            echo_active <= 1'b0;
            drop_active <= 1'b0;
        end
    end

endmodule

// ==== source/udp_reply_header.sv ====
/*
 * UDP reply header register
 * Holds one reply header with the ports swapped and the sender's
 * address as destination until the downstream stack takes it
 */
`timescale 1ns/100ps

module udp_reply_header (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    fwd_hdr_valid,
    output logic                    fwd_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  fwd_src_ip,
    input  udp_echo_pkg::udp_port_t fwd_src_port,
    input  udp_echo_pkg::udp_port_t fwd_dest_port,
    input  udp_echo_pkg::udp_len_t  fwd_length,

    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output udp_echo_pkg::ip_addr_t  m_hdr_dest_ip,
    output udp_echo_pkg::udp_port_t m_hdr_src_port,
    output udp_echo_pkg::udp_port_t m_hdr_dest_port,
    output udp_echo_pkg::udp_len_t  m_hdr_length
);

    logic full;

    udp_echo_pkg::ip_addr_t  dest_ip_reg;
    udp_echo_pkg::udp_port_t src_port_reg;
    udp_echo_pkg::udp_port_t dest_port_reg;
    udp_echo_pkg::udp_len_t  length_reg;

    // Single entry, so a new header only fits once the old one is gone
    assign fwd_hdr_ready = !full;
    assign m_hdr_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (fwd_hdr_valid && fwd_hdr_ready) begin
            full <= 1'b1;
        end else if (m_hdr_valid && m_hdr_ready) begin
            full <= 1'b0;
        end
    end

    // Reply goes back where the request came from
    always_ff @(posedge clk) begin
        if (fwd_hdr_valid && fwd_hdr_ready) begin
            dest_ip_reg <= fwd_src_ip;
            src_port_reg <= fwd_dest_port;
            dest_port_reg <= fwd_src_port;
            length_reg <= fwd_length;
        end
    end

    assign m_hdr_dest_ip = dest_ip_reg;
    assign m_hdr_src_port = src_port_reg;
    assign m_hdr_dest_port = dest_port_reg;
    assign m_hdr_length = length_reg;

endmodule

// ==== source/payload_fifo.sv ====
/*
 * Payload FIFO
 * Synchronous first-word-fall-through buffer for payload beats,
 * carrying keep, last and user alongside each data word
 */
`timescale 1ns/100ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst,

    input  udp_echo_pkg::data_t in_data,
    input  udp_echo_pkg::keep_t in_keep,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic                in_last,
    input  logic                in_user,

    output udp_echo_pkg::data_t out_data,
    output udp_echo_pkg::keep_t out_keep,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_last,
    output logic                out_user
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int WORD_WIDTH = udp_echo_pkg::DATA_WIDTH + udp_echo_pkg::KEEP_WIDTH + 2;

    logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];

    // Extra top bit tells a full buffer from an empty one
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    logic [WORD_WIDTH-1:0] in_word;
    logic [WORD_WIDTH-1:0] out_word;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in_ready = !full;
    assign out_valid = !empty;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    assign in_word = {in_user, in_last, in_keep, in_data};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head word is shown as soon as it is written
    assign out_word = mem[rd_ptr[ADDR_WIDTH-1:0]];

    assign out_data = out_word[udp_echo_pkg::DATA_WIDTH-1:0];
    assign out_keep = out_word[udp_echo_pkg::DATA_WIDTH +: udp_echo_pkg::KEEP_WIDTH];
    assign out_last = out_word[WORD_WIDTH-2];
    assign out_user = out_word[WORD_WIDTH-1];

endmodule

// ==== source/udp_echo_top.sv ====
/*
 * UDP echo service
 * Answers frames sent to the echo port with a swapped reply header
 * and a buffered copy of their payload, and drops everything else
 */
`timescale 1ns/100ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,

    // Parsed request header
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  s_hdr_src_ip,
    input  udp_echo_pkg::udp_port_t s_hdr_src_port,
    input  udp_echo_pkg::udp_port_t s_hdr_dest_port,
    input  udp_echo_pkg::udp_len_t  s_hdr_length,

    // Request payload
    input  udp_echo_pkg::data_t     s_payload_data,
    input  udp_echo_pkg::keep_t     s_payload_keep,
    input  logic                    s_payload_valid,
    output logic                    s_payload_ready,
    input  logic                    s_payload_last,
    input  logic                    s_payload_user,

    // Reply header
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output udp_echo_pkg::ip_addr_t  m_hdr_dest_ip,
    output udp_echo_pkg::udp_port_t m_hdr_src_port,
    output udp_echo_pkg::udp_port_t m_hdr_dest_port,
    output udp_echo_pkg::udp_len_t  m_hdr_length,

    // Reply payload
    output udp_echo_pkg::data_t     m_payload_data,
    output udp_echo_pkg::keep_t     m_payload_keep,
    output logic                    m_payload_valid,
    input  logic                    m_payload_ready,
    output logic                    m_payload_last,
    output logic                    m_payload_user
);

    logic                    fwd_hdr_valid;
    logic                    fwd_hdr_ready;
    udp_echo_pkg::ip_addr_t  fwd_src_ip;
    udp_echo_pkg::udp_port_t fwd_src_port;
    udp_echo_pkg::udp_port_t fwd_dest_port;
    udp_echo_pkg::udp_len_t  fwd_length;

    udp_echo_pkg::data_t     fifo_in_data;
    udp_echo_pkg::keep_t     fifo_in_keep;
    logic                    fifo_in_valid;
    logic                    fifo_in_ready;
    logic                    fifo_in_last;
    logic                    fifo_in_user;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) port_filter_inst (
        .clk(clk),
        .rst(rst),
        .s_hdr_valid(s_hdr_valid),
        .s_hdr_ready(s_hdr_ready),
        .s_hdr_src_ip(s_hdr_src_ip),
        .s_hdr_src_port(s_hdr_src_port),
        .s_hdr_dest_port(s_hdr_dest_port),
        .s_hdr_length(s_hdr_length),
        .s_payload_data(s_payload_data),
        .s_payload_keep(s_payload_keep),
        .s_payload_valid(s_payload_valid),
        .s_payload_ready(s_payload_ready),
        .s_payload_last(s_payload_last),
        .s_payload_user(s_payload_user),
        .fwd_hdr_valid(fwd_hdr_valid),
        .fwd_hdr_ready(fwd_hdr_ready),
        .fwd_src_ip(fwd_src_ip),
        .fwd_src_port(fwd_src_port),
        .fwd_dest_port(fwd_dest_port),
        .fwd_length(fwd_length),
        .fifo_in_data(fifo_in_data),
        .fifo_in_keep(fifo_in_keep),
        .fifo_in_valid(fifo_in_valid),
        .fifo_in_ready(fifo_in_ready),
        .fifo_in_last(fifo_in_last),
        .fifo_in_user(fifo_in_user)
    );

    udp_reply_header reply_header_inst (
        .clk(clk),
        .rst(rst),
        .fwd_hdr_valid(fwd_hdr_valid),
        .fwd_hdr_ready(fwd_hdr_ready),
        .fwd_src_ip(fwd_src_ip),
        .fwd_src_port(fwd_src_port),
        .fwd_dest_port(fwd_dest_port),
        .fwd_length(fwd_length),
        .m_hdr_valid(m_hdr_valid),
        .m_hdr_ready(m_hdr_ready),
        .m_hdr_dest_ip(m_hdr_dest_ip),
        .m_hdr_src_port(m_hdr_src_port),
        .m_hdr_dest_port(m_hdr_dest_port),
        .m_hdr_length(m_hdr_length)
    );

    // Decouples the echoed payload from reply back-pressure
    payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) payload_fifo_inst (
        .clk(clk),
        .rst(rst),
        .in_data(fifo_in_data),
        .in_keep(fifo_in_keep),
        .in_valid(fifo_in_valid),
        .in_ready(fifo_in_ready),
        .in_last(fifo_in_last),
        .in_user(fifo_in_user),
        .out_data(m_payload_data),
        .out_keep(m_payload_keep),
        .out_valid(m_payload_valid),
        .out_ready(m_payload_ready),
        .out_last(m_payload_last),
        .out_user(m_payload_user)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * Free running clock and a synchronous reset held for a set number of cycles
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD = 10.0,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Released between edges so the DUT never sees it change on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tb/udp_echo_tb.sv ====
/*
 * UDP echo testbench
 * Directed frames against the echo service, with a scoreboard that checks
 * reply headers and echoed payload beats as they leave the DUT
 */
`timescale 1ns/100ps

module udp_echo_tb;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234;
    localparam int FIFO_DEPTH = 16;
    localparam int LONG_BEATS = FIFO_DEPTH + 4;

    // Beats sent over all tests, used to bound the run
    localparam int TOTAL_BEATS = 4 + 5 + (3 + 6 + 2) + (LONG_BEATS + 3);
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 50 + 1000;

    logic clk;
    logic rst;

    logic                    s_hdr_valid;
    logic                    s_hdr_ready;
    udp_echo_pkg::ip_addr_t  s_hdr_src_ip;
    udp_echo_pkg::udp_port_t s_hdr_src_port;
    udp_echo_pkg::udp_port_t s_hdr_dest_port;
    udp_echo_pkg::udp_len_t  s_hdr_length;
    udp_echo_pkg::data_t     s_payload_data;
    udp_echo_pkg::keep_t     s_payload_keep;
    logic                    s_payload_valid;
    logic                    s_payload_ready;
    logic                    s_payload_last;
    logic                    s_payload_user;
    logic                    m_hdr_valid;
    logic                    m_hdr_ready;
    udp_echo_pkg::ip_addr_t  m_hdr_dest_ip;
    udp_echo_pkg::udp_port_t m_hdr_src_port;
    udp_echo_pkg::udp_port_t m_hdr_dest_port;
    udp_echo_pkg::udp_len_t  m_hdr_length;
    udp_echo_pkg::data_t     m_payload_data;
    udp_echo_pkg::keep_t     m_payload_keep;
    logic                    m_payload_valid;
    logic                    m_payload_ready;
    logic                    m_payload_last;
    logic                    m_payload_user;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int beats_accepted = 0;
    logic hdr_hold;
    logic payload_hold;
    logic [31:0] lfsr_state;

    // Expected replies, in output order
    udp_echo_pkg::ip_addr_t  exp_ip_q[$];
    udp_echo_pkg::udp_port_t exp_src_port_q[$];
    udp_echo_pkg::udp_port_t exp_dest_port_q[$];
    udp_echo_pkg::udp_len_t  exp_len_q[$];
    udp_echo_pkg::data_t     exp_data_q[$];
    udp_echo_pkg::keep_t     exp_keep_q[$];
    logic                    exp_last_q[$];
    logic                    exp_user_q[$];

    tb_clock_gen clock_gen (
        .clk(clk),
        .rst(rst)
    );

    udp_echo_top #(
        .ECHO_PORT(ECHO_PORT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) UUT (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken, LSB first
    function automatic udp_echo_pkg::data_t take_bits(input int n);
        udp_echo_pkg::data_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i] = lfsr_state[0];
        end
        return value;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input udp_echo_pkg::udp_port_t got,
                              input udp_echo_pkg::udp_port_t exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_ip(input string name, input udp_echo_pkg::ip_addr_t got,
                            input udp_echo_pkg::ip_addr_t exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_len(input string name, input udp_echo_pkg::udp_len_t got,
                             input udp_echo_pkg::udp_len_t exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_data(input string name, input udp_echo_pkg::data_t got,
                              input udp_echo_pkg::data_t exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_keep(input string name, input udp_echo_pkg::keep_t got,
                              input udp_echo_pkg::keep_t exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        compare_value(name, got, exp);
    endtask

    task automatic check_reply_header();
        if (exp_ip_q.size() == 0) begin
            errors++;
            $display("reply header to port %0d appeared with no request pending",
                     m_hdr_dest_port);
        end else begin
            check_ip("m_hdr_dest_ip", m_hdr_dest_ip, exp_ip_q.pop_front());
            check_port("m_hdr_src_port", m_hdr_src_port, exp_src_port_q.pop_front());
            check_port("m_hdr_dest_port", m_hdr_dest_port, exp_dest_port_q.pop_front());
            check_len("m_hdr_length", m_hdr_length, exp_len_q.pop_front());
        end
    endtask

    task automatic check_reply_beat();
        if (exp_data_q.size() == 0) begin
            errors++;
            $display("payload beat appeared with no echoed frame pending");
        end else begin
            check_data("m_payload_data", m_payload_data, exp_data_q.pop_front());
            check_keep("m_payload_keep", m_payload_keep, exp_keep_q.pop_front());
            check_flag("m_payload_last", m_payload_last, exp_last_q.pop_front());
            check_flag("m_payload_user", m_payload_user, exp_user_q.pop_front());
        end
    endtask

    // Outputs hold between edges, so ready and the checks share the falling edge
    always @(negedge clk) begin
        m_hdr_ready = !hdr_hold;
        m_payload_ready = !payload_hold;
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            check_reply_header();
        end
        if (!rst && m_payload_valid && m_payload_ready) begin
            check_reply_beat();
        end
    end

    task automatic send_frame(input udp_echo_pkg::ip_addr_t src_ip,
                              input udp_echo_pkg::udp_port_t src_port,
                              input udp_echo_pkg::udp_port_t dest_port,
                              input int beats);
        udp_echo_pkg::data_t data_q[$];
        udp_echo_pkg::keep_t keep_q[$];
        logic user_q[$];
        udp_echo_pkg::udp_len_t length;
        for (int i = 0; i < beats; i++) begin
            data_q.push_back(take_bits(64));
            keep_q.push_back((i == beats - 1) ? (8'hff >> take_bits(3)) : 8'hff);
            user_q.push_back(take_bits(1) != 0);
        end
        // UDP length counts the 8 byte header plus the payload bytes
        length = 16'(8 + 8 * (beats - 1) + $countones(keep_q[beats - 1]));
        if (dest_port == ECHO_PORT) begin
            exp_ip_q.push_back(src_ip);
            exp_src_port_q.push_back(dest_port);
            exp_dest_port_q.push_back(src_port);
            exp_len_q.push_back(length);
            for (int i = 0; i < beats; i++) begin
                exp_data_q.push_back(data_q[i]);
                exp_keep_q.push_back(keep_q[i]);
                exp_last_q.push_back(i == beats - 1);
                exp_user_q.push_back(user_q[i]);
            end
        end
        @(negedge clk);
        s_hdr_valid = 1'b1;
        s_hdr_src_ip = src_ip;
        s_hdr_src_port = src_port;
        s_hdr_dest_port = dest_port;
        s_hdr_length = length;
        // Ready settles just after the falling edge
        #1;
        while (!s_hdr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_hdr_valid = 1'b0;
        // Header fields stay put, the filter decides on them at the first beat
        for (int i = 0; i < beats; i++) begin
            s_payload_valid = 1'b1;
            s_payload_data = data_q[i];
            s_payload_keep = keep_q[i];
            s_payload_user = user_q[i];
            s_payload_last = (i == beats - 1);
            #1;
            while (!s_payload_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            beats_accepted++;
        end
        s_payload_valid = 1'b0;
        s_payload_last = 1'b0;
    endtask

    task automatic wait_for_replies(input int max_cycles);
        int n;
        n = 0;
        while ((exp_ip_q.size() != 0 || exp_data_q.size() != 0) && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_ip_q.size() != 0 || exp_data_q.size() != 0) begin
            errors++;
            $display("replies incomplete: %0d headers and %0d beats never came out",
                     exp_ip_q.size(), exp_data_q.size());
        end
        // Idle time so that stray outputs get caught
        repeat (10) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_reset_check();
        int errors_before;
        errors_before = errors;
        repeat (5) begin
            @(negedge clk);
            #1;
            check_flag("m_hdr_valid", m_hdr_valid, 1'b0);
            check_flag("m_payload_valid", m_payload_valid, 1'b0);
            check_flag("s_hdr_ready", s_hdr_ready, 1'b0);
            check_flag("s_payload_ready", s_payload_ready, 1'b0);
        end
        report_test("reset_state", errors_before);
    endtask

    task automatic echo_single_frame();
        int errors_before;
        errors_before = errors;
        send_frame(32'hc0a8_010a, 16'd40000, ECHO_PORT, 4);
        wait_for_replies(200);
        report_test("single_echo", errors_before);
    endtask

    task automatic discard_other_port();
        int errors_before;
        errors_before = errors;
        beats_accepted = 0;
        fork
            send_frame(32'h0a00_0005, 16'd5555, 16'd4321, 5);
            begin
                // Room for the header, the decision cycle and five beats
                repeat (5 + 4) @(posedge clk);
                if (beats_accepted != 5) begin
                    errors++;
                    $display("discarded frame had only %0d of 5 beats accepted in time",
                             beats_accepted);
                end
            end
        join
        wait_for_replies(50);
        report_test("discard", errors_before);
    endtask

    task automatic mix_match_and_drop();
        int errors_before;
        errors_before = errors;
        send_frame(32'h0a01_0203, 16'd1000, ECHO_PORT, 3);
        send_frame(32'h0a04_0506, 16'd2000, 16'd80, 6);
        send_frame(32'h0a07_0809, 16'd3000, ECHO_PORT, 2);
        wait_for_replies(300);
        report_test("mixed_sequence", errors_before);
    endtask

    task automatic apply_back_pressure();
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        hdr_hold = 1'b1;
        payload_hold = 1'b1;
        beats_accepted = 0;
        fork
            begin
                send_frame(32'hac10_0001, 16'd5000, ECHO_PORT, LONG_BEATS);
                send_frame(32'hac10_0002, 16'd5001, ECHO_PORT, 3);
            end
            begin
                repeat (60) @(posedge clk);
                if (beats_accepted != FIFO_DEPTH) begin
                    errors++;
                    $display("input took %0d beats while the FIFO of %0d was blocked",
                             beats_accepted, FIFO_DEPTH);
                end
                payload_hold = 1'b0;
                repeat (40) @(posedge clk);
                // Second header must wait behind the first reply
                if (!(s_hdr_valid && !s_hdr_ready)) begin
                    errors++;
                    $display("second header was not held back by the full reply register");
                end
                hdr_hold = 1'b0;
            end
        join
        wait_for_replies(400);
        report_test("back_pressure", errors_before);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        s_hdr_valid = 1'b0;
        s_hdr_src_ip = '0;
        s_hdr_src_port = '0;
        s_hdr_dest_port = '0;
        s_hdr_length = '0;
        s_payload_data = '0;
        s_payload_keep = '0;
        s_payload_valid = 1'b0;
        s_payload_last = 1'b0;
        s_payload_user = 1'b0;
        m_hdr_ready = 1'b1;
        m_payload_ready = 1'b1;
        hdr_hold = 1'b0;
        payload_hold = 1'b0;
        lfsr_state = 32'd42;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        run_reset_check();
        echo_single_frame();
        discard_other_port();
        mix_match_and_drop();
        apply_back_pressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/udp_echo_pkg.sv
source/udp_port_filter.sv
source/udp_reply_header.sv
source/payload_fifo.sv
source/udp_echo_top.sv
tb/tb_clock_gen.sv
tb/udp_echo_tb.sv
